/* tb.f */
+incdir+rtl
rtl/mgt_bus_pkg.sv
rtl/mgt_link_pkg.sv
rtl/mgt_reg_decode.sv
rtl/mgt_lane_regs.sv
rtl/mgt_read_collect.sv
rtl/mgt_reg_top.sv
verification/tb_clock_gen.sv
verification/mgt_reg_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f tb.f \
    --top-module mgt_reg_tb -o mgt_reg_sim \
    && ./obj_dir/mgt_reg_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/mgt_reg_tb.sv */
// directed testbench for the TLK2711 register manager
// register writes and reads, lane isolation, config-done strobes,
// interrupt capture, auto interrupt and soft reset

`include "mgt_defs.svh"

module mgt_reg_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N = `MGT_NUM_CH;
    // rough cycles per test, in test order
    localparam int TEST_CYCLES = N * 5 * 12 + 80 + N * 2 * 6 + N * 3 * 12 + N * 2 * 8
                                 + 60 + 2 * `MGT_SOFT_RST_CYCLES;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;
    localparam mgt_bus_pkg::reg_ofs_t CFG_OFS [5] = '{`MGT_TX_ADDR, `MGT_TX_LENGTH,
                                                      `MGT_TX_PACKET, `MGT_RX_ADDR, `MGT_RX_CTRL};

    logic                    clk;
    logic                    rst;
    logic                    reg_wen;
    mgt_bus_pkg::reg_addr_t  reg_waddr;
    mgt_bus_pkg::reg_data_t  reg_wdata;
    logic                    reg_ren;
    mgt_bus_pkg::reg_addr_t  reg_raddr;
    mgt_bus_pkg::reg_data_t  rdata;
    mgt_link_pkg::link_evt_t link_evt [N];
    mgt_link_pkg::tx_cfg_t   tx_cfg [N];
    mgt_link_pkg::rx_cfg_t   rx_cfg [N];
    logic [N-1:0]            tx_done;
    logic [N-1:0]            rx_done;
    logic [N-1:0]            tx_irq;
    logic [N-1:0]            rx_irq;
    logic [N-1:0]            loss_irq;
    logic                    soft_rst;

    int errors = 0;
    int cycles = 0;
    // last word written to each config register, by lane
    mgt_bus_pkg::reg_data_t model [N][5];

    tb_clock_gen clock_i (
        .clk (clk),
        .rst (rst)
    );

    mgt_reg_top dut_i (
        .clk              (clk),
        .rst              (rst),
        .i_reg_wen        (reg_wen),
        .i_reg_waddr      (reg_waddr),
        .i_reg_wdata      (reg_wdata),
        .i_reg_ren        (reg_ren),
        .i_reg_raddr      (reg_raddr),
        .o_reg_rdata      (rdata),
        .i_link_evt       (link_evt),
        .o_tx_cfg         (tx_cfg),
        .o_rx_cfg         (rx_cfg),
        .o_tx_config_done (tx_done),
        .o_rx_config_done (rx_done),
        .o_tx_irq         (tx_irq),
        .o_rx_irq         (rx_irq),
        .o_loss_irq       (loss_irq),
        .o_soft_rst       (soft_rst)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    endtask

    function automatic mgt_bus_pkg::reg_addr_t lane_addr(input int lane,
                                                         input mgt_bus_pkg::reg_ofs_t ofs);
        return `MGT_ADDR_BASE | mgt_bus_pkg::reg_addr_t'(lane << 8) | {8'd0, ofs};
    endfunction

    // returns on the falling edge right after the sampling edge
    task automatic bus_write(input mgt_bus_pkg::reg_addr_t addr,
                             input mgt_bus_pkg::reg_data_t data);
        @(negedge clk);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wen = 1'b0;
    endtask

    // word due after the third edge, zero after the others
    task automatic read_check(input mgt_bus_pkg::reg_addr_t addr,
                              input mgt_bus_pkg::reg_data_t exp, input string what);
        mgt_bus_pkg::reg_data_t want;
        @(negedge clk);
        reg_ren   = 1'b1;
        reg_raddr = addr;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            reg_ren = 1'b0;
            want = (k == 2) ? exp : '0;
            if (rdata !== want) report_mismatch(what, rdata, want);
        end
    endtask

    task automatic check_cfg();
        mgt_link_pkg::tx_cfg_t exp_tx;
        mgt_link_pkg::rx_cfg_t exp_rx;
        for (int n = 0; n < N; n++) begin
            exp_tx = {model[n][0][`MGT_DDR_ADDR_W-1:0], model[n][1][31:0],
                      model[n][2][15:0], model[n][2][31:16], model[n][2][47:32],
                      model[n][2][62:60], model[n][2][63], model[n][2][59]};
            exp_rx = {model[n][3][`MGT_DDR_ADDR_W-1:0], model[n][4][0], model[n][4][1],
                      model[n][4][2]};
            if (tx_cfg[n] !== exp_tx) report_mismatch("tx config", tx_cfg[n], exp_tx);
            if (rx_cfg[n] !== exp_rx) report_mismatch("rx config", rx_cfg[n], exp_rx);
        end
    endtask

    // config outputs carry the new word once the second edge has passed
    task automatic write_cfg(input int lane, input int idx, input mgt_bus_pkg::reg_data_t data);
        bus_write(lane_addr(lane, CFG_OFS[idx]), data);
        model[lane][idx] = data;
        @(negedge clk);
        check_cfg();
    endtask

    // mix bit 2 rx, bit 1 tx, bit 0 loss
    function automatic mgt_bus_pkg::reg_data_t irq_word(input logic [2:0] mix,
                                                        input mgt_link_pkg::link_evt_t e);
        mgt_bus_pkg::reg_data_t w;
        w = '0;
        if (mix[2]) begin
            w[63:60] = 4'd2;
            w[15:0]  = e.frame_len;
            w[31:16] = e.frame_num;
            w[32]    = e.checksum;
            w[33]    = e.file_end;
            w[41:34] = e.data_type;
        end else if (mix[1]) begin
            w[63:60] = 4'd1;
            w[15:0]  = 16'h5aa5;
        end else begin
            w[63:60] = 4'd3;
            w[0]     = e.link_loss;
            w[1]     = e.sync_loss;
            w[7:2]   = e.rx_status;
        end
        return w;
    endfunction

    ////////////////////
    // tests
    ////////////////////

    task automatic test_write_read();
        mgt_bus_pkg::reg_data_t data;
        for (int n = 0; n < N; n++) begin
            for (int r = 0; r < 5; r++) begin
                data = {$urandom, $urandom};
                // keep the auto interrupt start bit low
                if (r == 4) data[3] = 1'b0;
                write_cfg(n, r, data);
            end
        end
        for (int n = 0; n < N; n++) begin
            for (int r = 0; r < 5; r++) begin
                read_check(lane_addr(n, CFG_OFS[r]), model[n][r], "register read back");
            end
        end
    endtask

    task automatic test_isolation();
        write_cfg(1, 0, {$urandom, $urandom});
        // above and below the window
        bus_write({8'h20, `MGT_TX_ADDR}, {$urandom, $urandom});
        bus_write({8'h01, `MGT_RX_ADDR}, {$urandom, $urandom});
        repeat (2) @(negedge clk);
        check_cfg();
        read_check({8'h20, `MGT_TX_ADDR}, '0, "read outside window");
        read_check(lane_addr(2, 8'h18), '0, "read of unmapped offset");
        read_check(lane_addr(1, `MGT_SOFT_RST), '0, "read of soft reset offset");
    endtask

    task automatic test_config_done();
        logic [N-1:0] want;
        for (int n = 0; n < N; n++) begin
            for (int rx = 0; rx < 2; rx++) begin
                bus_write(lane_addr(n, (rx == 1) ? `MGT_RX_CFG : `MGT_TX_CFG),
                          {$urandom, $urandom});
                // edges 1 to 3, the strobe belongs to edge 2 only
                for (int e = 1; e <= 3; e++) begin
                    want = '0;
                    if (e == 2) want[n] = 1'b1;
                    if (tx_done !== ((rx == 0) ? want : '0))
                        report_mismatch("tx config done", tx_done, (rx == 0) ? want : '0);
                    if (rx_done !== ((rx == 1) ? want : '0))
                        report_mismatch("rx config done", rx_done, (rx == 1) ? want : '0);
                    @(negedge clk);
                end
            end
        end
        // data to the config offsets leaves the registers alone
        check_cfg();
    endtask

    task automatic test_interrupts();
        logic [63:0]            r;
        logic [2:0]             mix;
        logic [N-1:0]           one_hot;
        mgt_bus_pkg::reg_data_t want;
        for (int n = 0; n < N; n++) begin
            one_hot = '0;
            one_hot[n] = 1'b1;
            for (int m = 0; m < 3; m++) begin
                // all three together, then tx with loss, then loss alone
                mix = (m == 0) ? 3'b111 : ((m == 1) ? 3'b011 : 3'b001);
                r = {$urandom, $urandom};
                @(negedge clk);
                link_evt[n] = r[$bits(mgt_link_pkg::link_evt_t)-1:0];
                link_evt[n].rx_done = mix[2];
                link_evt[n].tx_done = mix[1];
                link_evt[n].loss    = mix[0];
                #1;
                if (rx_irq !== (mix[2] ? one_hot : '0))
                    report_mismatch("rx irq", rx_irq, mix[2] ? one_hot : '0);
                if (tx_irq !== (mix[1] ? one_hot : '0))
                    report_mismatch("tx irq", tx_irq, mix[1] ? one_hot : '0);
                if (loss_irq !== (mix[0] ? one_hot : '0))
                    report_mismatch("loss irq", loss_irq, mix[0] ? one_hot : '0);
                @(negedge clk);
                link_evt[n].rx_done = 1'b0;
                link_evt[n].tx_done = 1'b0;
                link_evt[n].loss    = 1'b0;
                read_check(lane_addr(n, `MGT_IRQ), irq_word(mix, link_evt[n]), "irq status");
            end
            want = '0;
            want[63:60] = 4'd9;
            want[9:0]   = link_evt[n].tx_status;
            read_check(lane_addr(n, `MGT_TX_STATUS), want, "tx status");
            want = '0;
            want[63:60] = 4'd10;
            want[5:0]   = link_evt[n].rx_status;
            read_check(lane_addr(n, `MGT_RX_STATUS), want, "rx status");
        end
    endtask

    task automatic test_auto_irq();
        mgt_bus_pkg::reg_data_t ctrl;
        mgt_bus_pkg::reg_data_t want;
        int                     pulses;
        int                     width;
        // width 2, gap 4, count 3, start
        ctrl = (64'd2 << 40) | (64'd4 << 12) | (64'd3 << 4) | 64'h8;
        write_cfg(2, 4, ctrl);
        pulses = 0;
        width  = 0;
        repeat (40) begin
            @(negedge clk);
            if (rx_irq[2]) begin
                width++;
            end else if (width != 0) begin
                pulses++;
                if (width != 2) report_mismatch("auto irq pulse width", width, 2);
                width = 0;
            end
        end
        if (pulses != 3) report_mismatch("auto irq pulse count", pulses, 3);
        want = '0;
        want[63:60] = 4'd4;
        want[15:0]  = 16'hffff;
        read_check(lane_addr(2, `MGT_IRQ), want, "auto irq status");
    endtask

    task automatic test_soft_reset();
        int len;
        bus_write(lane_addr(0, `MGT_SOFT_RST), '0);
        if (soft_rst !== 1'b0) report_mismatch("soft reset before edge 2", soft_rst, 0);
        len = 0;
        @(negedge clk);
        while (soft_rst === 1'b1 && len < 4 * `MGT_SOFT_RST_CYCLES) begin
            len++;
            @(negedge clk);
        end
        if (len != `MGT_SOFT_RST_CYCLES)
            report_mismatch("soft reset length", len, `MGT_SOFT_RST_CYCLES);
    endtask

    initial begin
        void'($urandom(32'h4c07c173));
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_ren   = 1'b0;
        reg_raddr = '0;
        for (int n = 0; n < N; n++) begin
            link_evt[n] = '0;
            for (int r = 0; r < 5; r++) begin
                model[n][r] = '0;
            end
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        if ({soft_rst, tx_done, rx_done, rdata} !== '0)
            report_mismatch("outputs after reset", {soft_rst, tx_done, rx_done, rdata}, 0);
        check_cfg();

        test_write_read();
        test_isolation();
        test_config_done();
        test_interrupts();
        test_auto_irq();
        test_soft_reset();

        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock and reset
// 10 ns clock, synchronous reset held over the first two rising edges

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* rtl/mgt_reg_top.sv */
// register manager top for the four lane TLK2711 link controller
// bus decoder, one register bank per lane and the read collector

`include "mgt_defs.svh"

module mgt_reg_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_reg_wen,
    input  mgt_bus_pkg::reg_addr_t  i_reg_waddr,
    input  mgt_bus_pkg::reg_data_t  i_reg_wdata,
    input  logic                    i_reg_ren,
    input  mgt_bus_pkg::reg_addr_t  i_reg_raddr,
    output mgt_bus_pkg::reg_data_t  o_reg_rdata,
    input  mgt_link_pkg::link_evt_t i_link_evt [`MGT_NUM_CH],
    output mgt_link_pkg::tx_cfg_t   o_tx_cfg [`MGT_NUM_CH],
    output mgt_link_pkg::rx_cfg_t   o_rx_cfg [`MGT_NUM_CH],
    output logic [`MGT_NUM_CH-1:0]  o_tx_config_done,
    output logic [`MGT_NUM_CH-1:0]  o_rx_config_done,
    output logic [`MGT_NUM_CH-1:0]  o_tx_irq,
    output logic [`MGT_NUM_CH-1:0]  o_rx_irq,
    output logic [`MGT_NUM_CH-1:0]  o_loss_irq,
    output logic                    o_soft_rst
);

    mgt_bus_pkg::lane_req_t  lane_req [`MGT_NUM_CH];
    mgt_bus_pkg::reg_data_t  lane_rdata [`MGT_NUM_CH];
    mgt_link_pkg::lane_irq_t lane_irq [`MGT_NUM_CH];
    mgt_bus_pkg::lane_idx_t  rd_lane;

    mgt_reg_decode decode_i (
        .clk         (clk),
        .rst         (rst),
        .i_reg_wen   (i_reg_wen),
        .i_reg_waddr (i_reg_waddr),
        .i_reg_wdata (i_reg_wdata),
        .i_reg_ren   (i_reg_ren),
        .i_reg_raddr (i_reg_raddr),
        .o_lane_req  (lane_req),
        .o_rd_lane   (rd_lane),
        .o_soft_rst  (o_soft_rst)
    );

    for (genvar n = 0; n < `MGT_NUM_CH; n++) begin : g_lane
        mgt_lane_regs lane_i (
            .clk              (clk),
            .rst              (rst),
            .i_req            (lane_req[n]),
            .i_link_evt       (i_link_evt[n]),
            .o_tx_cfg         (o_tx_cfg[n]),
            .o_rx_cfg         (o_rx_cfg[n]),
            .o_tx_config_done (o_tx_config_done[n]),
            .o_rx_config_done (o_rx_config_done[n]),
            .o_irq            (lane_irq[n]),
            .o_rdata          (lane_rdata[n])
        );

        assign o_tx_irq[n]   = lane_irq[n].tx;
        assign o_rx_irq[n]   = lane_irq[n].rx;
        assign o_loss_irq[n] = lane_irq[n].loss;
    end

    mgt_read_collect collect_i (
        .clk          (clk),
        .rst          (rst),
        .i_rd_lane    (rd_lane),
        .i_lane_rdata (lane_rdata),
        .o_reg_rdata  (o_reg_rdata)
    );

endmodule

/* rtl/mgt_read_collect.sv */
// read collector
// selects the addressed lane's read word and drives the bus

`include "mgt_defs.svh"

module mgt_read_collect (
    input  logic                   clk,
    input  logic                   rst,
    input  mgt_bus_pkg::lane_idx_t i_rd_lane,
    input  mgt_bus_pkg::reg_data_t i_lane_rdata [`MGT_NUM_CH],
    output mgt_bus_pkg::reg_data_t o_reg_rdata
);

    mgt_bus_pkg::lane_idx_t rd_lane_q;

    // one more stage to meet the bank mux output
    always_ff @(posedge clk) begin
        rd_lane_q <= i_rd_lane;
    end

    // banks drive zero when idle, so the bus is zero outside a read
    always_ff @(posedge clk) begin
        if (rst) begin
            o_reg_rdata <= '0;
        end else begin
            o_reg_rdata <= i_lane_rdata[rd_lane_q];
        end
    end

endmodule

/* rtl/mgt_lane_regs.sv */
// one lane's register bank
// holds DMA and packet config, pulses config-done, captures link
// interrupts and generates a repeating test interrupt on request

`include "mgt_defs.svh"

module mgt_lane_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  mgt_bus_pkg::lane_req_t  i_req,
    input  mgt_link_pkg::link_evt_t i_link_evt,
    output mgt_link_pkg::tx_cfg_t   o_tx_cfg,
    output mgt_link_pkg::rx_cfg_t   o_rx_cfg,
    output logic                    o_tx_config_done,
    output logic                    o_rx_config_done,
    output mgt_link_pkg::lane_irq_t o_irq,
    output mgt_bus_pkg::reg_data_t  o_rdata
);

    typedef enum logic [1:0] {AUTO_IDLE, AUTO_GAP, AUTO_PULSE} auto_state_t;

    mgt_bus_pkg::reg_data_t tx_addr_q;
    mgt_bus_pkg::reg_data_t tx_len_q;
    mgt_bus_pkg::reg_data_t tx_pkt_q;
    mgt_bus_pkg::reg_data_t rx_addr_q;
    mgt_bus_pkg::reg_data_t rx_ctrl_q;
    mgt_bus_pkg::reg_data_t irq_status;

    auto_state_t auto_state;
    logic [27:0] auto_cnt;
    logic [27:0] auto_cnt_nxt;
    logic [7:0]  auto_rep;
    logic        auto_start_q;
    logic        auto_rise;
    logic        auto_pulse;
    logic [7:0]  auto_times;
    logic [27:0] auto_gap;
    logic [7:0]  auto_width;

    ////////////////////
    // config registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_addr_q <= '0;
            tx_len_q  <= '0;
            tx_pkt_q  <= '0;
            rx_addr_q <= '0;
            rx_ctrl_q <= '0;
        end else if (i_req.wen) begin
            case (i_req.ofs)
                `MGT_TX_ADDR:   tx_addr_q <= i_req.wdata;
                `MGT_TX_LENGTH: tx_len_q  <= i_req.wdata;
                `MGT_TX_PACKET: tx_pkt_q  <= i_req.wdata;
                `MGT_RX_ADDR:   rx_addr_q <= i_req.wdata;
                `MGT_RX_CTRL:   rx_ctrl_q <= i_req.wdata;
                default: ;
            endcase
        end
    end

    // data written to the two config offsets is don't care
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tx_config_done <= 1'b0;
            o_rx_config_done <= 1'b0;
        end else begin
            o_tx_config_done <= i_req.wen && (i_req.ofs == `MGT_TX_CFG);
            o_rx_config_done <= i_req.wen && (i_req.ofs == `MGT_RX_CFG);
        end
    end

    assign o_tx_cfg.base_addr = tx_addr_q[`MGT_DDR_ADDR_W-1:0];
    assign o_tx_cfg.total_len = tx_len_q[31:0];
    assign o_tx_cfg.body      = tx_pkt_q[15:0];
    assign o_tx_cfg.body_num  = tx_pkt_q[31:16];
    assign o_tx_cfg.tail      = tx_pkt_q[47:32];
    assign o_tx_cfg.pre_emph  = tx_pkt_q[59];
    assign o_tx_cfg.mode      = tx_pkt_q[62:60];
    assign o_tx_cfg.loopback  = tx_pkt_q[63];

    assign o_rx_cfg.base_addr     = rx_addr_q[`MGT_DDR_ADDR_W-1:0];
    assign o_rx_cfg.fifo_rd       = rx_ctrl_q[0];
    assign o_rx_cfg.link_loss_det = rx_ctrl_q[1];
    assign o_rx_cfg.sync_loss_det = rx_ctrl_q[2];

    ////////////////////
    // auto interrupt
    ////////////////////

    assign auto_times   = rx_ctrl_q[11:4];
    assign auto_gap     = rx_ctrl_q[39:12];
    assign auto_width   = rx_ctrl_q[47:40];
    assign auto_rise    = rx_ctrl_q[3] && !auto_start_q;
    assign auto_pulse   = (auto_state == AUTO_PULSE);
    assign auto_cnt_nxt = auto_cnt + 1'b1;

    // gap and width of zero still last one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            auto_state   <= AUTO_IDLE;
            auto_cnt     <= '0;
            auto_rep     <= '0;
            auto_start_q <= 1'b0;
        end else begin
            auto_start_q <= rx_ctrl_q[3];
            case (auto_state)
                AUTO_IDLE: begin
                    auto_cnt <= '0;
                    auto_rep <= '0;
                    if (auto_rise && (auto_times != 8'd0)) begin
                        auto_state <= AUTO_GAP;
                    end
                end
                AUTO_GAP: begin
                    if (auto_cnt_nxt >= auto_gap) begin
                        auto_cnt   <= '0;
                        auto_state <= AUTO_PULSE;
                    end else begin
                        auto_cnt <= auto_cnt_nxt;
                    end
                end
                AUTO_PULSE: begin
                    if (auto_cnt_nxt >= {20'd0, auto_width}) begin
                        auto_cnt   <= '0;
                        auto_rep   <= auto_rep + 1'b1;
                        auto_state <= (auto_rep + 1'b1 >= auto_times) ? AUTO_IDLE : AUTO_GAP;
                    end else begin
                        auto_cnt <= auto_cnt_nxt;
                    end
                end
                default: auto_state <= AUTO_IDLE;
            endcase
        end
    end

    ////////////////////
    // interrupt status
    ////////////////////

    // rx first, then tx, loss and the test generator
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_status <= '0;
        end else if (i_link_evt.rx_done) begin
            irq_status <= {mgt_link_pkg::IRQ_CAUSE_RX, 18'd0, i_link_evt.data_type,
                           i_link_evt.file_end, i_link_evt.checksum,
                           i_link_evt.frame_num, i_link_evt.frame_len};
        end else if (i_link_evt.tx_done) begin
            irq_status <= {mgt_link_pkg::IRQ_CAUSE_TX, 44'd0, 16'h5aa5};
        end else if (i_link_evt.loss) begin
            irq_status <= {mgt_link_pkg::IRQ_CAUSE_LOSS, 52'd0, i_link_evt.rx_status,
                           i_link_evt.sync_loss, i_link_evt.link_loss};
        end else if (auto_pulse) begin
            irq_status <= {mgt_link_pkg::IRQ_CAUSE_AUTO, 44'd0, 16'hffff};
        end
    end

    assign o_irq.tx   = i_link_evt.tx_done;
    assign o_irq.rx   = i_link_evt.rx_done || auto_pulse;
    assign o_irq.loss = i_link_evt.loss;

    // read mux, zero whenever no read is addressed here
    always_ff @(posedge clk) begin
        if (rst || !i_req.ren) begin
            o_rdata <= '0;
        end else begin
            case (i_req.ofs)
                `MGT_TX_ADDR:   o_rdata <= tx_addr_q;
                `MGT_TX_LENGTH: o_rdata <= tx_len_q;
                `MGT_TX_PACKET: o_rdata <= tx_pkt_q;
                `MGT_RX_ADDR:   o_rdata <= rx_addr_q;
                `MGT_RX_CTRL:   o_rdata <= rx_ctrl_q;
                `MGT_IRQ:       o_rdata <= irq_status;
                `MGT_TX_STATUS: o_rdata <= {`MGT_TAG_TX_STATUS, 50'd0, i_link_evt.tx_status};
                `MGT_RX_STATUS: o_rdata <= {`MGT_TAG_RX_STATUS, 54'd0, i_link_evt.rx_status};
                default:        o_rdata <= '0;
            endcase
        end
    end

endmodule

/* rtl/mgt_reg_decode.sv */
// register bus decoder
// checks the address window, splits lane and offset, registers one
// request per lane and times the global soft reset

`include "mgt_defs.svh"

module mgt_reg_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_reg_wen,
    input  mgt_bus_pkg::reg_addr_t i_reg_waddr,
    input  mgt_bus_pkg::reg_data_t i_reg_wdata,
    input  logic                   i_reg_ren,
    input  mgt_bus_pkg::reg_addr_t i_reg_raddr,
    output mgt_bus_pkg::lane_req_t o_lane_req [`MGT_NUM_CH],
    output mgt_bus_pkg::lane_idx_t o_rd_lane,
    output logic                   o_soft_rst
);

    localparam int CNT_W = $clog2(`MGT_SOFT_RST_CYCLES);

    logic                  wr_hit;
    logic                  rd_hit;
    logic [3:0]            wr_field;
    logic [3:0]            rd_field;
    mgt_bus_pkg::reg_ofs_t wr_ofs;
    mgt_bus_pkg::reg_ofs_t rd_ofs;
    logic                  soft_hit;
    logic                  soft_hit_q;
    logic [CNT_W-1:0]      soft_cnt;

    // lane field in bits 11:8, offset in bits 7:0
    assign wr_field = i_reg_waddr[11:8];
    assign rd_field = i_reg_raddr[11:8];
    assign wr_ofs   = i_reg_waddr[7:0];
    assign rd_ofs   = i_reg_raddr[7:0];

    // lane fields past the last lane fall outside the map
    assign wr_hit = i_reg_wen && (wr_field < `MGT_NUM_CH)
                    && ((i_reg_waddr & ~`MGT_ADDR_MASK) == `MGT_ADDR_BASE);
    assign rd_hit = i_reg_ren && (rd_field < `MGT_NUM_CH)
                    && ((i_reg_raddr & ~`MGT_ADDR_MASK) == `MGT_ADDR_BASE);

    assign soft_hit = wr_hit && (wr_field == 4'd0) && (wr_ofs == `MGT_SOFT_RST);

    ////////////////////
    // per lane request
    ////////////////////

    for (genvar n = 0; n < `MGT_NUM_CH; n++) begin : g_req
        logic wr_sel;
        logic rd_sel;

        assign wr_sel = wr_hit && (wr_field == n);
        // the request carries one offset, a write to the same lane wins
        assign rd_sel = rd_hit && (rd_field == n) && !wr_sel;

        always_ff @(posedge clk) begin
            if (rst) begin
                o_lane_req[n].wen <= 1'b0;
                o_lane_req[n].ren <= 1'b0;
            end else begin
                o_lane_req[n].wen <= wr_sel;
                o_lane_req[n].ren <= rd_sel;
            end
            o_lane_req[n].ofs   <= wr_sel ? wr_ofs : rd_ofs;
            o_lane_req[n].wdata <= i_reg_wdata;
        end
    end

    // lane of the read in flight, lines up with the bank mux one cycle later
    always_ff @(posedge clk) begin
        o_rd_lane <= mgt_bus_pkg::lane_idx_t'(rd_field);
    end

    ////////////////////
    // soft reset timer
    ////////////////////

    // a new write reloads the count while the pulse is running
    always_ff @(posedge clk) begin
        if (rst) begin
            soft_hit_q <= 1'b0;
            o_soft_rst <= 1'b0;
            soft_cnt   <= '0;
        end else begin
            soft_hit_q <= soft_hit;
            if (soft_hit_q) begin
                o_soft_rst <= 1'b1;
                soft_cnt   <= CNT_W'(`MGT_SOFT_RST_CYCLES - 1);
            end else if (o_soft_rst) begin
                if (soft_cnt == '0) begin
                    o_soft_rst <= 1'b0;
                end else begin
                    soft_cnt <= soft_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/mgt_link_pkg.sv */
// link side types
// lane configuration, link events and interrupt levels

`include "mgt_defs.svh"

package mgt_link_pkg;

    typedef logic [`MGT_DDR_ADDR_W-1:0] ddr_addr_t;
    typedef logic [3:0] irq_cause_t;

    // cause codes in bits 63:60 of the interrupt status word
    localparam irq_cause_t IRQ_CAUSE_TX   = 4'd1;
    localparam irq_cause_t IRQ_CAUSE_RX   = 4'd2;
    localparam irq_cause_t IRQ_CAUSE_LOSS = 4'd3;
    localparam irq_cause_t IRQ_CAUSE_AUTO = 4'd4;

    typedef struct packed {
        ddr_addr_t   base_addr;
        logic [31:0] total_len;
        logic [15:0] body;
        logic [15:0] body_num;
        logic [15:0] tail;
        logic [2:0]  mode;
        logic        loopback;
        logic        pre_emph;
    } tx_cfg_t;

    typedef struct packed {
        ddr_addr_t base_addr;
        logic      fifo_rd;
        logic      link_loss_det;
        logic      sync_loss_det;
    } rx_cfg_t;

    // pulses and frame info from one lane's link
    typedef struct packed {
        logic        tx_done;
        logic        rx_done;
        logic        loss;
        logic [15:0] frame_len;
        logic [15:0] frame_num;
        logic [7:0]  data_type;
        logic        file_end;
        logic        checksum;
        logic [5:0]  rx_status;
        logic [9:0]  tx_status;
        logic        sync_loss;
        logic        link_loss;
    } link_evt_t;

    typedef struct packed {
        logic tx;
        logic rx;
        logic loss;
    } lane_irq_t;

endpackage

/* rtl/mgt_bus_pkg.sv */
// register bus types
// address, data word, lane index and the per lane request

`include "mgt_defs.svh"

package mgt_bus_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [63:0] reg_data_t;
    typedef logic [$clog2(`MGT_NUM_CH)-1:0] lane_idx_t;
    typedef logic [7:0] reg_ofs_t;

    // request from the decoder to one lane bank
    typedef struct packed {
        logic      wen;
        logic      ren;
        reg_ofs_t  ofs;
        reg_data_t wdata;
    } lane_req_t;

endpackage

/* rtl/mgt_defs.svh */
// shared constants for the four lane TLK2711 register manager
// address window, register map, status tags and soft reset length

`ifndef MGT_DEFS_SVH
`define MGT_DEFS_SVH

// lanes and widths
`define MGT_NUM_CH            4
`define MGT_DDR_ADDR_W        32

// register window, bits outside the mask must equal the base
`define MGT_ADDR_BASE         16'h1000
`define MGT_ADDR_MASK         16'h0fff

// per lane register offsets, address bits 7:0
`define MGT_TX_CFG            8'h08
`define MGT_RX_CFG            8'h10
`define MGT_TX_ADDR           8'h20
`define MGT_TX_LENGTH         8'h28
`define MGT_TX_PACKET         8'h30
`define MGT_TX_STATUS         8'h38
`define MGT_RX_ADDR           8'h40
`define MGT_RX_CTRL           8'h48
`define MGT_RX_STATUS         8'h50
`define MGT_IRQ               8'h60
// global, only decoded with lane field 0
`define MGT_SOFT_RST          8'h70

`define MGT_SOFT_RST_CYCLES   16

// tags in bits 63:60 of a status read
`define MGT_TAG_TX_STATUS     4'd9
`define MGT_TAG_RX_STATUS     4'd10

`endif
